// ==== hw/rf_decd_pkg.sv ====
`default_nettype none

package rf_decd_pkg;

    // ----------------------------------------
    // widths
    // ----------------------------------------
    localparam int XLEN        = 64;    // source-1 immediate
    localparam int INST_W      = 32;
    localparam int FUNC_W      = 5;     // alu sub-function
    localparam int ALU_SEL_W   = 21;    // one-hot alu op select
    localparam int MULT_FUNC_W = 8;

    // execution unit select
    typedef enum logic [1:0] {
        EU_NONE = 2'd0,
        EU_ALU  = 2'd1,
        EU_MULT = 2'd2
    } eu_sel_e;

    // one-hot alu operations, bit positions follow the alu datapath
    typedef enum logic [ALU_SEL_W-1:0] {
        NON_ALU     = 21'h000000,
        ADDER_ADD   = 21'h000001,
        ADDER_ADDW  = 21'h000002,
        ADDER_SUB   = 21'h000004,
        ADDER_SUBW  = 21'h000008,
        ADDER_SLT   = 21'h000010,
        SHIFTER_SL  = 21'h000020,
        SHIFTER_SR  = 21'h000040,
        SHIFTER_SLW = 21'h000080,
        SHIFTER_SRW = 21'h000100,
        LOGIC_AND   = 21'h000400,   // bit 9 held by the extract unit
        LOGIC_OR    = 21'h000800,
        LOGIC_XOR   = 21'h001000,
        LOGIC_LUI   = 21'h002000,
        LOGIC_CLI   = 21'h004000,
        MISC_MV     = 21'h008000
    } alu_op_e;

    // ----------------------------------------
    // bundles
    // ----------------------------------------
    typedef struct packed {
        eu_sel_e             eu_sel;
        logic [FUNC_W-1:0]   func;
        alu_op_e             alu_sel;
    } decd_ctrl_t;

    typedef struct packed {
        logic                vld;
        logic [INST_W-1:0]   opcode;
    } issue_t;

    typedef struct packed {
        logic                   vld;
        decd_ctrl_t             ctrl;
        logic [MULT_FUNC_W-1:0] mult_func;
        logic [XLEN-1:0]        src1_imm;
    } decd_out_t;

    localparam decd_ctrl_t CTRL_NONE = '{eu_sel: EU_NONE, func: '0, alu_sel: NON_ALU};
    localparam decd_ctrl_t CTRL_MULT = '{eu_sel: EU_MULT, func: '0, alu_sel: NON_ALU};

    // one table row for an alu instruction
    function automatic decd_ctrl_t alu_ctrl(input logic [FUNC_W-1:0] func, input alu_op_e sel);
        decd_ctrl_t c;
        c.eu_sel  = EU_ALU;
        c.func    = func;
        c.alu_sel = sel;
        return c;
    endfunction

endpackage

`default_nettype wire

// ==== hw/rf_imm_gen.sv ====
`timescale 1ns/1ps
`default_nettype none

module rf_imm_gen (
    input  logic [rf_decd_pkg::INST_W-1:0] opcode,
    output logic [rf_decd_pkg::XLEN-1:0]   src1_imm
);

    logic [4:0] imm_sel;        // one-hot immediate format
    logic [9:0] addi16sp_imm;
    logic [9:0] addi4spn_imm;

    // ----------------------------------------
    // format select
    // ----------------------------------------
    // lui / auipc
    assign imm_sel[0] = (opcode[6:0] == 7'b0110111) || (opcode[6:0] == 7'b0010111);

    // any other 32-bit word takes imm12
    assign imm_sel[1] = (opcode[1:0] == 2'b11) && !imm_sel[0];

    // compressed imm6 unless one of the stack forms
    assign imm_sel[2] = (opcode[1:0] != 2'b11) && !imm_sel[3] && !imm_sel[4];

    assign imm_sel[3] = ({opcode[15:13], opcode[11:7], opcode[1:0]} == 10'b011_00010_01);
    assign imm_sel[4] = ({opcode[15:13], opcode[1:0]} == 5'b000_00);

    // ----------------------------------------
    // scrambled stack immediates
    // ----------------------------------------
    // multiple of 16, signed
    assign addi16sp_imm = {opcode[12], opcode[4:3], opcode[5], opcode[2], opcode[6], 4'b0};

    // multiple of 4, unsigned
    assign addi4spn_imm = {opcode[10:7], opcode[12:11], opcode[5], opcode[6], 2'b0};

    always_comb begin
        case (imm_sel)
            5'b00001: src1_imm = {{(rf_decd_pkg::XLEN-20){1'b0}}, opcode[31:12]};
            5'b00010: src1_imm = {{(rf_decd_pkg::XLEN-12){opcode[31]}}, opcode[31:20]};
            5'b00100: begin
                src1_imm = {{(rf_decd_pkg::XLEN-6){opcode[12]}}, opcode[12], opcode[6:2]};
            end
            5'b01000: begin
                src1_imm = {{(rf_decd_pkg::XLEN-10){addi16sp_imm[9]}}, addi16sp_imm};
            end
            5'b10000: src1_imm = {{(rf_decd_pkg::XLEN-10){1'b0}}, addi4spn_imm};
            default:  src1_imm = '0;    // selects are exclusive
        endcase
    end

endmodule

`default_nettype wire

// ==== hw/rf_decd_16.sv ====
`timescale 1ns/1ps
`default_nettype none

module rf_decd_16 (
    input  logic [rf_decd_pkg::INST_W-1:0] opcode,
    output rf_decd_pkg::decd_ctrl_t        ctrl
);

    // key is funct3 + funct2 bits, funct2 of CA form, quadrant
    always_comb begin
        casez ({opcode[15:10], opcode[6:5], opcode[1:0]})
            // ----------------------------------------
            // quadrant 0
            // ----------------------------------------
            10'b000???_??00: // c.addi4spn
                ctrl = rf_decd_pkg::alu_ctrl(5'd0, rf_decd_pkg::ADDER_ADD);
            // ----------------------------------------
            // quadrant 1
            // ----------------------------------------
            10'b000???_??01: // c.addi, c.nop
                ctrl = rf_decd_pkg::alu_ctrl(5'd0, rf_decd_pkg::ADDER_ADD);
            10'b001???_??01: // c.addiw
                ctrl = rf_decd_pkg::alu_ctrl(5'd1, rf_decd_pkg::ADDER_ADDW);
            10'b010???_??01: // c.li
                ctrl = rf_decd_pkg::alu_ctrl(5'd16, rf_decd_pkg::LOGIC_CLI);
            10'b011???_??01: begin
                // rd == sp picks c.addi16sp, else c.lui
                if (opcode[11:7] == 5'd2) begin
                    ctrl = rf_decd_pkg::alu_ctrl(5'd0, rf_decd_pkg::ADDER_ADD);
                end else begin
                    ctrl = rf_decd_pkg::alu_ctrl(5'd8, rf_decd_pkg::LOGIC_LUI);
                end
            end
            10'b100?00_??01: // c.srli
                ctrl = rf_decd_pkg::alu_ctrl(5'd1, rf_decd_pkg::SHIFTER_SR);
            10'b100?01_??01: // c.srai
                ctrl = rf_decd_pkg::alu_ctrl(5'd3, rf_decd_pkg::SHIFTER_SR);
            10'b100?10_??01: // c.andi
                ctrl = rf_decd_pkg::alu_ctrl(5'd1, rf_decd_pkg::LOGIC_AND);
            10'b100011_0001: // c.sub
                ctrl = rf_decd_pkg::alu_ctrl(5'd2, rf_decd_pkg::ADDER_SUB);
            10'b100011_0101: // c.xor
                ctrl = rf_decd_pkg::alu_ctrl(5'd4, rf_decd_pkg::LOGIC_XOR);
            10'b100011_1001: // c.or
                ctrl = rf_decd_pkg::alu_ctrl(5'd2, rf_decd_pkg::LOGIC_OR);
            10'b100011_1101: // c.and
                ctrl = rf_decd_pkg::alu_ctrl(5'd1, rf_decd_pkg::LOGIC_AND);
            10'b100111_0001: // c.subw
                ctrl = rf_decd_pkg::alu_ctrl(5'd3, rf_decd_pkg::ADDER_SUBW);
            10'b100111_0101: // c.addw
                ctrl = rf_decd_pkg::alu_ctrl(5'd1, rf_decd_pkg::ADDER_ADDW);
            // ----------------------------------------
            // quadrant 2
            // ----------------------------------------
            10'b000???_??10: // c.slli
                ctrl = rf_decd_pkg::alu_ctrl(5'd0, rf_decd_pkg::SHIFTER_SL);
            10'b1000??_??10: // c.mv
                ctrl = rf_decd_pkg::alu_ctrl(5'd0, rf_decd_pkg::MISC_MV);
            10'b1001??_??10: // c.add
                ctrl = rf_decd_pkg::alu_ctrl(5'd0, rf_decd_pkg::ADDER_ADD);
            default:
                ctrl = rf_decd_pkg::CTRL_NONE;  // not for this pipe
        endcase
    end

endmodule

`default_nettype wire

// ==== hw/rf_decd_32.sv ====
`timescale 1ns/1ps
`default_nettype none

module rf_decd_32 (
    input  logic [rf_decd_pkg::INST_W-1:0]      opcode,
    output rf_decd_pkg::decd_ctrl_t             ctrl,
    output logic [rf_decd_pkg::MULT_FUNC_W-1:0] mult_func
);

    logic mula_muls;    // accumulate family pattern

    // ----------------------------------------
    // mult func, straight from opcode bits
    // ----------------------------------------
    // kept off the table path for timing
    assign mula_muls = ({opcode[27:26], opcode[4]} == 3'b000);

    assign mult_func[0] = (opcode[13:12] != 2'b00) && opcode[4];
    assign mult_func[1] = opcode[3] && !mula_muls;
    assign mult_func[2] = (opcode[3] && !mula_muls) || (opcode[13:12] == 2'b11);
    assign mult_func[3] = (opcode[3] && !mula_muls) || opcode[13];
    assign mult_func[4] = opcode[27];
    assign mult_func[5] = !opcode[4];
    assign mult_func[6] = mula_muls;
    assign mult_func[7] = opcode[25] && !opcode[4];

    // ----------------------------------------
    // main table, funct7 / funct3 / op[6:2]
    // ----------------------------------------
    always_comb begin
        casez ({opcode[31:25], opcode[14:12], opcode[6:2]})
            15'b???????_???_01101: // lui
                ctrl = rf_decd_pkg::alu_ctrl(5'd8, rf_decd_pkg::LOGIC_LUI);
            // op-imm
            15'b???????_000_00100: // addi
                ctrl = rf_decd_pkg::alu_ctrl(5'd0, rf_decd_pkg::ADDER_ADD);
            15'b???????_010_00100: // slti
                ctrl = rf_decd_pkg::alu_ctrl(5'd6, rf_decd_pkg::ADDER_SLT);
            15'b???????_011_00100: // sltiu
                ctrl = rf_decd_pkg::alu_ctrl(5'd14, rf_decd_pkg::ADDER_SLT);
            15'b???????_100_00100: // xori
                ctrl = rf_decd_pkg::alu_ctrl(5'd4, rf_decd_pkg::LOGIC_XOR);
            15'b???????_110_00100: // ori
                ctrl = rf_decd_pkg::alu_ctrl(5'd2, rf_decd_pkg::LOGIC_OR);
            15'b???????_111_00100: // andi
                ctrl = rf_decd_pkg::alu_ctrl(5'd1, rf_decd_pkg::LOGIC_AND);
            15'b000000?_001_00100: // slli, shamt[5] free
                ctrl = rf_decd_pkg::alu_ctrl(5'd0, rf_decd_pkg::SHIFTER_SL);
            15'b000000?_101_00100: // srli
                ctrl = rf_decd_pkg::alu_ctrl(5'd1, rf_decd_pkg::SHIFTER_SR);
            15'b010000?_101_00100: // srai
                ctrl = rf_decd_pkg::alu_ctrl(5'd3, rf_decd_pkg::SHIFTER_SR);
            // op-imm-32
            15'b???????_000_00110: // addiw
                ctrl = rf_decd_pkg::alu_ctrl(5'd1, rf_decd_pkg::ADDER_ADDW);
            15'b0000000_001_00110: // slliw
                ctrl = rf_decd_pkg::alu_ctrl(5'd4, rf_decd_pkg::SHIFTER_SLW);
            15'b0000000_101_00110: // srliw
                ctrl = rf_decd_pkg::alu_ctrl(5'd5, rf_decd_pkg::SHIFTER_SRW);
            15'b0100000_101_00110: // sraiw
                ctrl = rf_decd_pkg::alu_ctrl(5'd7, rf_decd_pkg::SHIFTER_SRW);
            // op-32
            15'b0000000_000_01110: // addw
                ctrl = rf_decd_pkg::alu_ctrl(5'd1, rf_decd_pkg::ADDER_ADDW);
            15'b0100000_000_01110: // subw
                ctrl = rf_decd_pkg::alu_ctrl(5'd3, rf_decd_pkg::ADDER_SUBW);
            15'b0000000_001_01110: // sllw
                ctrl = rf_decd_pkg::alu_ctrl(5'd4, rf_decd_pkg::SHIFTER_SLW);
            15'b0000000_101_01110: // srlw
                ctrl = rf_decd_pkg::alu_ctrl(5'd5, rf_decd_pkg::SHIFTER_SRW);
            15'b0100000_101_01110: // sraw
                ctrl = rf_decd_pkg::alu_ctrl(5'd7, rf_decd_pkg::SHIFTER_SRW);
            // op
            15'b0000000_000_01100: // add
                ctrl = rf_decd_pkg::alu_ctrl(5'd0, rf_decd_pkg::ADDER_ADD);
            15'b0100000_000_01100: // sub
                ctrl = rf_decd_pkg::alu_ctrl(5'd2, rf_decd_pkg::ADDER_SUB);
            15'b0000000_001_01100: // sll
                ctrl = rf_decd_pkg::alu_ctrl(5'd0, rf_decd_pkg::SHIFTER_SL);
            15'b0000000_010_01100: // slt
                ctrl = rf_decd_pkg::alu_ctrl(5'd6, rf_decd_pkg::ADDER_SLT);
            15'b0000000_011_01100: // sltu
                ctrl = rf_decd_pkg::alu_ctrl(5'd14, rf_decd_pkg::ADDER_SLT);
            15'b0000000_100_01100: // xor
                ctrl = rf_decd_pkg::alu_ctrl(5'd4, rf_decd_pkg::LOGIC_XOR);
            15'b0000000_101_01100: // srl
                ctrl = rf_decd_pkg::alu_ctrl(5'd1, rf_decd_pkg::SHIFTER_SR);
            15'b0100000_101_01100: // sra
                ctrl = rf_decd_pkg::alu_ctrl(5'd3, rf_decd_pkg::SHIFTER_SR);
            15'b0000000_110_01100: // or
                ctrl = rf_decd_pkg::alu_ctrl(5'd2, rf_decd_pkg::LOGIC_OR);
            15'b0000000_111_01100: // and
                ctrl = rf_decd_pkg::alu_ctrl(5'd1, rf_decd_pkg::LOGIC_AND);
            // mul, mulh, mulhsu, mulhu, mulw
            15'b0000001_000_01100,
            15'b0000001_001_01100,
            15'b0000001_010_01100,
            15'b0000001_011_01100,
            15'b0000001_000_01110:
                ctrl = rf_decd_pkg::CTRL_MULT;
            default:
                ctrl = rf_decd_pkg::CTRL_NONE;
        endcase
    end

endmodule

`default_nettype wire

// ==== hw/rf_pipe1_decd.sv ====
`timescale 1ns/1ps
`default_nettype none

module rf_pipe1_decd (
    input  logic                    forever_cpuclk,
    input  logic                    rst,
    input  rf_decd_pkg::issue_t     issue,
    output rf_decd_pkg::decd_out_t  decd_out
);

    rf_decd_pkg::decd_ctrl_t              ctrl_16;
    rf_decd_pkg::decd_ctrl_t              ctrl_32;
    rf_decd_pkg::decd_ctrl_t              ctrl_sel;
    logic [rf_decd_pkg::MULT_FUNC_W-1:0]  mult_func;
    logic [rf_decd_pkg::XLEN-1:0]         src1_imm;
    logic                                 is_32;

    // ----------------------------------------
    // decoders, all combinational
    // ----------------------------------------
    rf_imm_gen rf_imm_gen_inst (
        .opcode   (issue.opcode),
        .src1_imm (src1_imm)
    );

    rf_decd_16 rf_decd_16_inst (
        .opcode (issue.opcode),
        .ctrl   (ctrl_16)
    );

    rf_decd_32 rf_decd_32_inst (
        .opcode    (issue.opcode),
        .ctrl      (ctrl_32),
        .mult_func (mult_func)
    );

    assign is_32    = (issue.opcode[1:0] == 2'b11);   // length from quadrant bits
    assign ctrl_sel = is_32 ? ctrl_32 : ctrl_16;

    // ----------------------------------------
    // output stage
    // ----------------------------------------
    always_ff @(posedge forever_cpuclk) begin
        if (rst) begin
            decd_out.vld <= 1'b0;
        end else begin
            decd_out.vld <= issue.vld;
        end
        // payload holds between instructions
        if (issue.vld) begin
            decd_out.ctrl      <= ctrl_sel;
            decd_out.mult_func <= mult_func;    // only meaningful for EU_MULT
            decd_out.src1_imm  <= src1_imm;
        end
    end

endmodule

`default_nettype wire

// ==== tb/rf_pipe1_decd_properties.sv ====
`timescale 1ns/1ps
`default_nettype none

module rf_pipe1_decd_properties (
    input logic                   forever_cpuclk,
    input logic                   rst,
    input rf_decd_pkg::decd_out_t decd_out
);

    // valid cleared by reset
    vld_after_rst: assert property (@(posedge forever_cpuclk) rst |=> !decd_out.vld)
        else $error("decd_out.vld high in the cycle after reset");

    // ----------------------------------------
    // control bundle, valid results only
    // ----------------------------------------
    none_is_empty: assert property (@(posedge forever_cpuclk) disable iff (rst)
        decd_out.vld && decd_out.ctrl.eu_sel == rf_decd_pkg::EU_NONE
        |-> decd_out.ctrl.func == 5'd0 && decd_out.ctrl.alu_sel == rf_decd_pkg::NON_ALU)
        else $error("EU_NONE result carries a func or alu_sel");

    sel_onehot: assert property (@(posedge forever_cpuclk) disable iff (rst)
        decd_out.vld |-> $onehot0(decd_out.ctrl.alu_sel))
        else $error("alu_sel has more than one bit set");

    mult_not_alu: assert property (@(posedge forever_cpuclk) disable iff (rst)
        decd_out.vld && decd_out.ctrl.eu_sel == rf_decd_pkg::EU_MULT
        |-> decd_out.ctrl.alu_sel == rf_decd_pkg::NON_ALU)
        else $error("EU_MULT result selects an alu operation");

endmodule

bind rf_pipe1_decd rf_pipe1_decd_properties rf_pipe1_decd_properties_inst (
    .forever_cpuclk (forever_cpuclk),
    .rst            (rst),
    .decd_out       (decd_out)
);

`default_nettype wire

// ==== tb/rf_pipe1_decd_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module rf_pipe1_decd_tb;

    logic                    forever_cpuclk;
    logic                    rst;
    rf_decd_pkg::issue_t     issue;
    rf_decd_pkg::decd_out_t  decd_out;

    logic [27:0] exp_ctrl;      // {eu_sel, func, alu_sel}
    logic [7:0]  exp_mult;
    logic [63:0] exp_imm;
    logic        exp_vld;
    int          cycle_cnt = 0;

    rf_pipe1_decd rf_pipe1_decd_inst (
        .forever_cpuclk (forever_cpuclk),
        .rst            (rst),
        .issue          (issue),
        .decd_out       (decd_out)
    );

    initial begin
        forever_cpuclk = 1'b0;
        forever begin
            #50 forever_cpuclk = ~forever_cpuclk;
        end
    end

    // 2 reset cycles + 2000 test cycles, with some margin
    always @(posedge forever_cpuclk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= 2100) begin
            $display("timeout: the run did not finish within 2100 cycles");
            $display("TEST FAILED");
            $fatal(1, "simulation timed out");
        end
    end

    task automatic report_mismatch(input string name, input logic [63:0] got,
                                   input logic [63:0] exp);
        $display("ERROR at %0t ns: %s got 0x%0h expected 0x%0h", $time, name, got, exp);
        $display("TEST FAILED");
        $fatal(1, "mismatch on %s", name);
    endtask

    // ----------------------------------------
    // reference model
    // ----------------------------------------
    function automatic logic [27:0] alu_expect(input int func, input int sel_bit);
        return {2'd1, 5'(func), (21'(1) << sel_bit)};
    endfunction

    // shared funct3 rows of op and op-imm
    function automatic logic [27:0] arith_row(input logic [2:0] f3);
        case (f3)
            3'd0: return alu_expect(0, 0);
            3'd1: return alu_expect(0, 5);
            3'd2: return alu_expect(6, 4);
            3'd3: return alu_expect(14, 4);
            3'd4: return alu_expect(4, 12);
            3'd5: return alu_expect(1, 6);
            3'd6: return alu_expect(2, 11);
            default: return alu_expect(1, 10);
        endcase
    endfunction

    function automatic logic [27:0] model_32(input logic [31:0] op);
        logic [6:0]  f7;
        logic [2:0]  f3;
        logic [27:0] r;
        f7 = op[31:25];
        f3 = op[14:12];
        r = '0;
        case (op[6:2])
            5'b01101: r = alu_expect(8, 13);    // lui
            5'b00100: begin
                if (f3 == 3'd1 || f3 == 3'd5) begin
                    if (f7[6:1] == 6'd0) r = arith_row(f3);
                    else if (f3 == 3'd5 && f7[6:1] == 6'b010000) r = alu_expect(3, 6);
                end else begin
                    r = arith_row(f3);
                end
            end
            5'b00110: begin                     // op-imm-32
                if (f3 == 3'd0) r = alu_expect(1, 1);
                else if (f3 == 3'd1 && f7 == 7'h00) r = alu_expect(4, 7);
                else if (f3 == 3'd5 && f7 == 7'h00) r = alu_expect(5, 8);
                else if (f3 == 3'd5 && f7 == 7'h20) r = alu_expect(7, 8);
            end
            5'b01110: begin                     // op-32
                if (f7 == 7'h01 && f3 == 3'd0) r = {2'd2, 26'd0};
                else if (f7 == 7'h00 && f3 == 3'd0) r = alu_expect(1, 1);
                else if (f7 == 7'h00 && f3 == 3'd1) r = alu_expect(4, 7);
                else if (f7 == 7'h00 && f3 == 3'd5) r = alu_expect(5, 8);
                else if (f7 == 7'h20 && f3 == 3'd0) r = alu_expect(3, 3);
                else if (f7 == 7'h20 && f3 == 3'd5) r = alu_expect(7, 8);
            end
            5'b01100: begin
                if (f7 == 7'h01 && f3 <= 3'd3) r = {2'd2, 26'd0};
                else if (f7 == 7'h00) r = arith_row(f3);
                else if (f7 == 7'h20 && f3 == 3'd0) r = alu_expect(2, 2);
                else if (f7 == 7'h20 && f3 == 3'd5) r = alu_expect(3, 6);
            end
            default: r = '0;
        endcase
        return r;
    endfunction

    function automatic logic [27:0] model_16(input logic [31:0] op);
        logic [2:0]  f3;
        logic [27:0] r;
        f3 = op[15:13];
        r = '0;
        if (op[1:0] == 2'b00 && f3 == 3'd0) begin
            r = alu_expect(0, 0);               // c.addi4spn
        end else if (op[1:0] == 2'b01) begin
            case (f3)
                3'd0: r = alu_expect(0, 0);
                3'd1: r = alu_expect(1, 1);
                3'd2: r = alu_expect(16, 14);
                3'd3: r = (op[11:7] == 5'd2) ? alu_expect(0, 0) : alu_expect(8, 13);
                3'd4: begin
                    casez ({op[12:10], op[6:5]})
                        5'b?_00_??: r = alu_expect(1, 6);
                        5'b?_01_??: r = alu_expect(3, 6);
                        5'b?_10_??: r = alu_expect(1, 10);
                        5'b0_11_00: r = alu_expect(2, 2);
                        5'b0_11_01: r = alu_expect(4, 12);
                        5'b0_11_10: r = alu_expect(2, 11);
                        5'b0_11_11: r = alu_expect(1, 10);
                        5'b1_11_00: r = alu_expect(3, 3);
                        5'b1_11_01: r = alu_expect(1, 1);
                        default: r = '0;
                    endcase
                end
                default: r = '0;
            endcase
        end else if (op[1:0] == 2'b10) begin
            if (f3 == 3'd0) r = alu_expect(0, 5);
            else if (f3 == 3'd4) r = op[12] ? alu_expect(0, 0) : alu_expect(0, 15);
        end
        return r;
    endfunction

    function automatic logic [7:0] mult_expect(input logic [31:0] op);
        if (op[6:2] == 5'b01110) return 8'h0E;  // mulw
        case (op[13:12])
            2'd0: return 8'h00;
            2'd1: return 8'h01;
            2'd2: return 8'h09;
            default: return 8'h0D;
        endcase
    endfunction

    function automatic logic [63:0] imm_expect(input logic [31:0] op);
        logic [63:0] v;
        v = '0;
        if (op[1:0] == 2'b11) begin
            if (op[6:0] == 7'h37 || op[6:0] == 7'h17) v[19:0] = op[31:12];
            else v = 64'($signed(op[31:20]));
        end else if (op[15:13] == 3'b011 && op[11:7] == 5'd2 && op[1:0] == 2'b01) begin
            v[9]   = op[12];
            v[8:7] = op[4:3];
            v[6]   = op[5];
            v[5]   = op[2];
            v[4]   = op[6];
            v      = 64'($signed(v[9:0]));
        end else if (op[15:13] == 3'b000 && op[1:0] == 2'b00) begin
            v[9:6] = op[10:7];
            v[5:4] = op[12:11];
            v[3]   = op[5];
            v[2]   = op[6];
        end else begin
            v = 64'($signed({op[12], op[6:2]}));
        end
        return v;
    endfunction

    // ----------------------------------------
    // stimulus and checks
    // ----------------------------------------
    function automatic logic [31:0] make_word(input int kind);
        logic [31:0] w;
        w = $urandom;
        if (kind == 1) begin                    // 32-bit, fields stay random
            case ($urandom % 6)
                0: w[6:0] = 7'h37;
                1: w[6:0] = 7'h17;
                2: w[6:0] = 7'h13;
                3: w[6:0] = 7'h1B;
                4: w[6:0] = 7'h33;
                default: w[6:0] = 7'h3B;
            endcase
            if (w[6:0] != 7'h37 && w[6:0] != 7'h17 && ($urandom % 3) != 0) begin
                case ($urandom % 4)
                    0: w[31:25] = 7'h00;
                    1: w[31:25] = 7'h20;
                    2: w[31:25] = 7'h01;
                    default: w[31:25] = 7'h21;
                endcase
            end
        end else if (kind == 2) begin           // compressed
            w[1:0] = 2'($urandom % 3);
            if (($urandom % 4) == 0) w[11:7] = 5'd2;    // hit the sp forms
        end
        return w;
    endfunction

    task automatic check_result();
        assert (decd_out.vld === exp_vld)
            else report_mismatch("decd_out.vld", 64'(decd_out.vld), 64'(exp_vld));
        if (exp_vld) begin
            assert (decd_out.ctrl.eu_sel === exp_ctrl[27:26])
                else report_mismatch("decd_out.ctrl.eu_sel", 64'(decd_out.ctrl.eu_sel),
                                     64'(exp_ctrl[27:26]));
            assert (decd_out.ctrl.func === exp_ctrl[25:21])
                else report_mismatch("decd_out.ctrl.func", 64'(decd_out.ctrl.func),
                                     64'(exp_ctrl[25:21]));
            assert (decd_out.ctrl.alu_sel === exp_ctrl[20:0])
                else report_mismatch("decd_out.ctrl.alu_sel", 64'(decd_out.ctrl.alu_sel),
                                     64'(exp_ctrl[20:0]));
            if (exp_ctrl[27:26] == 2'd2) begin
                assert (decd_out.mult_func === exp_mult)
                    else report_mismatch("decd_out.mult_func", 64'(decd_out.mult_func),
                                         64'(exp_mult));
            end
            assert (decd_out.src1_imm === exp_imm)
                else report_mismatch("decd_out.src1_imm", decd_out.src1_imm, exp_imm);
        end
    endtask

    initial begin
        int          kind;
        logic [31:0] word;
        void'($urandom(32'hbe47));
        rst = 1'b1;
        issue = '0;
        exp_vld = 1'b0;
        exp_ctrl = '0;
        exp_mult = '0;
        exp_imm = '0;
        repeat (2) @(posedge forever_cpuclk);
        #1;
        rst = 1'b0;
        assert (decd_out.vld === 1'b0)
            else report_mismatch("decd_out.vld", 64'(decd_out.vld), 64'(0));
        for (int i = 0; i < 2000; i++) begin
            kind = $urandom % 10;
            word = make_word(kind < 2 ? 0 : (kind < 6 ? 1 : (kind < 9 ? 2 : 3)));
            issue.vld = (kind >= 2);            // 0, 1 idle
            issue.opcode = word;
            exp_vld = issue.vld;
            if (issue.vld) begin
                exp_ctrl = (word[1:0] == 2'b11) ? model_32(word) : model_16(word);
                exp_mult = mult_expect(word);
                exp_imm = imm_expect(word);
            end
            @(posedge forever_cpuclk);
            #1;
            check_result();
        end
        $display("TEST OK");
        $finish;
    end

endmodule

`default_nettype wire

// ==== build.f ====
hw/rf_decd_pkg.sv
hw/rf_imm_gen.sv
hw/rf_decd_16.sv
hw/rf_decd_32.sv
hw/rf_pipe1_decd.sv
tb/rf_pipe1_decd_properties.sv
tb/rf_pipe1_decd_tb.sv

// ==== run.sh ====
#!/bin/sh
# compile and run the rf_pipe1_decd testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
    --top-module rf_pipe1_decd_tb \
    -f build.f \
    -o rf_pipe1_decd_sim
if [ $? -ne 0 ]; then
    echo "verilator compile failed"
    exit 1
fi

out=$(./obj_dir/rf_pipe1_decd_sim 2>&1)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$out" | grep -qx "TEST OK"; then
    exit 0
fi
exit 1
